// File: Bender.yml
package:
  name: dbg_support

sources:
  - include_dirs:
      - logic
    files:
      - logic/trig_pkg.sv
      - logic/obi_pkg.sv
      - logic/trig_cfg_regs.sv
      - logic/trig_match.sv
      - logic/obi_resp_tracker.sv
      - logic/dbg_support_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/dbg_support_props.sv
      - sim/tb_dbg_support.sv

// File: logic/dbg_support_macros.svh
`ifndef DBG_SUPPORT_MACROS_SVH
`define DBG_SUPPORT_MACROS_SVH

// trigger bank size
`define DBG_NUM_TRIGGERS        4
`define DBG_TRIG_IDX_W          2
// type field 15 means the trigger is disabled
`define DBG_TDATA1_DEFAULT      32'hF800_0000

// tdata1 field positions
`define DBG_TYPE_MSB            31
`define DBG_TYPE_LSB            28
`define DBG_TYPE_MCONTROL       2
`define DBG_TYPE_MCONTROL6      6
`define DBG_BIT_LOAD            0
`define DBG_BIT_STORE           1
`define DBG_BIT_EXECUTE         2
`define DBG_BIT_U_MODE          3
`define DBG_BIT_M_MODE          6
`define DBG_MATCH_MSB           10
`define DBG_MATCH_LSB           7
`define DBG_MATCH_EQ            0
`define DBG_MATCH_GE            2
`define DBG_MATCH_LT            3

// data bus attribute FIFO depth
`define DBG_OBI_MAX_OUTSTANDING 4

`endif

// File: logic/dbg_support_top.sv
`include "dbg_support_macros.svh"

module dbg_support_top (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  // trigger configuration
  input  logic                 cfg_we_i,
  input  trig_pkg::trig_idx_t  cfg_sel_i,
  input  trig_pkg::tdata_t     cfg_tdata1_i,
  input  trig_pkg::tdata_t     cfg_tdata2_i,
  input  trig_pkg::trig_idx_t  rd_sel_i,
  output trig_pkg::tdata_t     rd_tdata1_o,
  output trig_pkg::tdata_t     rd_tdata2_o,
  // retirement
  input  logic                 retire_valid_i,
  input  obi_pkg::obi_addr_t   retire_pc_i,
  input  trig_pkg::priv_t      retire_priv_i,
  input  obi_pkg::obi_addr_t   mem_addr_i,
  input  trig_pkg::byte_mask_t mem_rmask_i,
  input  trig_pkg::byte_mask_t mem_wmask_i,
  output logic                 match_valid_o,
  output trig_pkg::trig_vec_t  match_execute_o,
  output trig_pkg::trig_vec_t  match_load_o,
  output trig_pkg::trig_vec_t  match_store_o,
  // data bus
  input  logic                 bus_req_i,
  input  logic                 bus_gnt_i,
  input  logic                 bus_rvalid_i,
  input  logic                 bus_req_is_store_i,
  output logic                 resp_was_store_o,
  output obi_pkg::obi_cnt_t    outstanding_o,
  output logic                 addr_ph_cont_o
);

  trig_pkg::tdata_t [`DBG_NUM_TRIGGERS-1:0] tdata1_all;
  trig_pkg::tdata_t [`DBG_NUM_TRIGGERS-1:0] tdata2_all;

  trig_cfg_regs u_cfg_regs (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_sel_i     (cfg_sel_i),
    .cfg_tdata1_i  (cfg_tdata1_i),
    .cfg_tdata2_i  (cfg_tdata2_i),
    .rd_sel_i      (rd_sel_i),
    .rd_tdata1_o   (rd_tdata1_o),
    .rd_tdata2_o   (rd_tdata2_o),
    .tdata1_all_o  (tdata1_all),
    .tdata2_all_o  (tdata2_all)
  );

  trig_match u_match (
    .in_support_if   (in_support_if),
    .rst_n_i         (rst_n_i),
    .tdata1_all_i    (tdata1_all),
    .tdata2_all_i    (tdata2_all),
    .retire_valid_i  (retire_valid_i),
    .retire_pc_i     (retire_pc_i),
    .retire_priv_i   (retire_priv_i),
    .mem_addr_i      (mem_addr_i),
    .mem_rmask_i     (mem_rmask_i),
    .mem_wmask_i     (mem_wmask_i),
    .match_valid_o   (match_valid_o),
    .match_execute_o (match_execute_o),
    .match_load_o    (match_load_o),
    .match_store_o   (match_store_o)
  );

  obi_resp_tracker u_tracker (
    .in_support_if      (in_support_if),
    .rst_n_i            (rst_n_i),
    .bus_req_i          (bus_req_i),
    .bus_gnt_i          (bus_gnt_i),
    .bus_rvalid_i       (bus_rvalid_i),
    .bus_req_is_store_i (bus_req_is_store_i),
    .resp_was_store_o   (resp_was_store_o),
    .outstanding_o      (outstanding_o),
    .addr_ph_cont_o     (addr_ph_cont_o)
  );

endmodule : dbg_support_top

// File: logic/obi_pkg.sv
`include "dbg_support_macros.svh"

package obi_pkg;

  typedef logic [31:0] obi_addr_t;

  // needs to hold the full depth, not just depth-1
  typedef logic [$clog2(`DBG_OBI_MAX_OUTSTANDING+1)-1:0] obi_cnt_t;

  // address phase tracking
  typedef enum logic {
    ADDR_IDLE,
    ADDR_WAIT_GNT
  } addr_ph_state_e;

endpackage : obi_pkg

// File: logic/obi_resp_tracker.sv
`include "dbg_support_macros.svh"

module obi_resp_tracker (
  input  logic              in_support_if,
  input  logic              rst_n_i,
  input  logic              bus_req_i,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  logic              bus_req_is_store_i,
  output logic              resp_was_store_o,
  output obi_pkg::obi_cnt_t outstanding_o,
  output logic              addr_ph_cont_o
);

  localparam int DEPTH = `DBG_OBI_MAX_OUTSTANDING;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  obi_pkg::addr_ph_state_e state_q;
  obi_pkg::addr_ph_state_e state_d;

  logic [DEPTH-1:0] attr_mem;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             push;
  logic             pop;

  // --------------------
  // address phase FSM
  // --------------------

  // wait state means last cycle saw req without gnt
  always_comb begin
    state_d = state_q;
    case (state_q)
      obi_pkg::ADDR_IDLE:     if (bus_req_i && !bus_gnt_i) state_d = obi_pkg::ADDR_WAIT_GNT;
      obi_pkg::ADDR_WAIT_GNT: if (bus_gnt_i || !bus_req_i) state_d = obi_pkg::ADDR_IDLE;
      default:                state_d = obi_pkg::ADDR_IDLE;
    endcase
  end

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      state_q <= obi_pkg::ADDR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign addr_ph_cont_o = bus_req_i && (state_q == obi_pkg::ADDR_WAIT_GNT);

  // --------------------
  // store attribute FIFO
  // --------------------

  assign push = bus_req_i && bus_gnt_i;
  assign pop  = bus_rvalid_i;

  always_ff @(posedge in_support_if) begin
    if (push) begin
      attr_mem[wr_ptr_q] <= bus_req_is_store_i;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      outstanding_o <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == DEPTH-1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
      end
      // accept and response together keep the count
      case ({push, pop})
        2'b10:   outstanding_o <= outstanding_o + 1'b1;
        2'b01:   outstanding_o <= outstanding_o - 1'b1;
        default: outstanding_o <= outstanding_o;
      endcase
    end
  end

  // response always belongs to the oldest entry
  assign resp_was_store_o = attr_mem[rd_ptr_q];

endmodule : obi_resp_tracker

// File: logic/trig_cfg_regs.sv
`include "dbg_support_macros.svh"

module trig_cfg_regs (
  input  logic                                         in_support_if,
  input  logic                                         rst_n_i,
  input  logic                                         cfg_we_i,
  input  trig_pkg::trig_idx_t                          cfg_sel_i,
  input  trig_pkg::tdata_t                             cfg_tdata1_i,
  input  trig_pkg::tdata_t                             cfg_tdata2_i,
  input  trig_pkg::trig_idx_t                          rd_sel_i,
  output trig_pkg::tdata_t                             rd_tdata1_o,
  output trig_pkg::tdata_t                             rd_tdata2_o,
  output trig_pkg::tdata_t [`DBG_NUM_TRIGGERS-1:0]     tdata1_all_o,
  output trig_pkg::tdata_t [`DBG_NUM_TRIGGERS-1:0]     tdata2_all_o
);

  // --------------------
  // register bank
  // --------------------

  // each trigger only reacts to its own select, so out of range writes
  // simply hit no register
  for (genvar t = 0; t < `DBG_NUM_TRIGGERS; t++) begin : g_bank
    always_ff @(posedge in_support_if) begin
      if (!rst_n_i) begin
        tdata1_all_o[t] <= `DBG_TDATA1_DEFAULT;
        tdata2_all_o[t] <= '0;
      end else if (cfg_we_i && (int'(cfg_sel_i) == t)) begin
        tdata1_all_o[t] <= cfg_tdata1_i;
        tdata2_all_o[t] <= cfg_tdata2_i;
      end
    end
  end

  // --------------------
  // read port
  // --------------------

  always_comb begin
    rd_tdata1_o = '0;
    rd_tdata2_o = '0;
    if (int'(rd_sel_i) < `DBG_NUM_TRIGGERS) begin
      rd_tdata1_o = tdata1_all_o[rd_sel_i];
      rd_tdata2_o = tdata2_all_o[rd_sel_i];
    end
  end

endmodule : trig_cfg_regs

// File: logic/trig_match.sv
`include "dbg_support_macros.svh"

module trig_match (
  input  logic                                     in_support_if,
  input  logic                                     rst_n_i,
  input  trig_pkg::tdata_t [`DBG_NUM_TRIGGERS-1:0] tdata1_all_i,
  input  trig_pkg::tdata_t [`DBG_NUM_TRIGGERS-1:0] tdata2_all_i,
  input  logic                                     retire_valid_i,
  input  obi_pkg::obi_addr_t                       retire_pc_i,
  input  trig_pkg::priv_t                          retire_priv_i,
  input  obi_pkg::obi_addr_t                       mem_addr_i,
  input  trig_pkg::byte_mask_t                     mem_rmask_i,
  input  trig_pkg::byte_mask_t                     mem_wmask_i,
  output logic                                     match_valid_o,
  output trig_pkg::trig_vec_t                      match_execute_o,
  output trig_pkg::trig_vec_t                      match_load_o,
  output trig_pkg::trig_vec_t                      match_store_o
);

  localparam int MATCH_W = `DBG_MATCH_MSB - `DBG_MATCH_LSB + 1;
  localparam int LANES   = $bits(trig_pkg::byte_mask_t);

  trig_pkg::trig_vec_t eligible;
  trig_pkg::trig_vec_t exec_hit;
  trig_pkg::trig_vec_t load_raw;
  trig_pkg::trig_vec_t store_raw;
  trig_pkg::trig_vec_t load_hit;
  trig_pkg::trig_vec_t store_hit;

  // compare one address against tdata2, unknown modes never hit
  function automatic logic cmp_hit(input logic [MATCH_W-1:0] mode,
                                   input obi_pkg::obi_addr_t value,
                                   input trig_pkg::tdata_t   limit);
    logic hit;
    case (mode)
      `DBG_MATCH_EQ: hit = (value == limit);
      `DBG_MATCH_GE: hit = (value >= limit);
      `DBG_MATCH_LT: hit = (value <  limit);
      default:       hit = 1'b0;
    endcase
    return hit;
  endfunction

  // --------------------
  // per trigger compare
  // --------------------

  for (genvar t = 0; t < `DBG_NUM_TRIGGERS; t++) begin : g_trig
    trig_pkg::tdata_t                  tdata1;
    trig_pkg::tdata_t                  tdata2;
    logic [MATCH_W-1:0]                match_f;
    logic                              type_ok;
    logic                              mode_en;
    trig_pkg::byte_mask_t              lane_hit;

    assign tdata1  = tdata1_all_i[t];
    assign tdata2  = tdata2_all_i[t];
    assign match_f = tdata1[`DBG_MATCH_MSB:`DBG_MATCH_LSB];

    // only mcontrol and mcontrol6 are address triggers here
    assign type_ok = (tdata1[`DBG_TYPE_MSB:`DBG_TYPE_LSB] == `DBG_TYPE_MCONTROL) ||
                     (tdata1[`DBG_TYPE_MSB:`DBG_TYPE_LSB] == `DBG_TYPE_MCONTROL6);
    assign mode_en = ((retire_priv_i == trig_pkg::PRIV_M) && tdata1[`DBG_BIT_M_MODE]) ||
                     ((retire_priv_i == trig_pkg::PRIV_U) && tdata1[`DBG_BIT_U_MODE]);

    assign eligible[t] = retire_valid_i && type_ok && mode_en;

    // every byte of the access is a candidate address
    for (genvar k = 0; k < LANES; k++) begin : g_lane
      assign lane_hit[k] = cmp_hit(match_f, mem_addr_i + 32'(k), tdata2);
    end

    assign exec_hit[t]  = eligible[t] && tdata1[`DBG_BIT_EXECUTE] &&
                          cmp_hit(match_f, retire_pc_i, tdata2);
    assign load_raw[t]  = eligible[t] && tdata1[`DBG_BIT_LOAD] && |(mem_rmask_i & lane_hit);
    assign store_raw[t] = eligible[t] && tdata1[`DBG_BIT_STORE] && |(mem_wmask_i & lane_hit);
  end

  // an execute hit on any trigger takes priority over all data hits
  assign load_hit  = (|exec_hit) ? '0 : load_raw;
  assign store_hit = (|exec_hit) ? '0 : store_raw;

  // --------------------
  // result stage
  // --------------------

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      match_valid_o   <= 1'b0;
      match_execute_o <= '0;
      match_load_o    <= '0;
      match_store_o   <= '0;
    end else begin
      match_valid_o   <= retire_valid_i;
      match_execute_o <= exec_hit;
      match_load_o    <= load_hit;
      match_store_o   <= store_hit;
    end
  end

endmodule : trig_match

// File: logic/trig_pkg.sv
`include "dbg_support_macros.svh"

package trig_pkg;

  // one tdata1 or tdata2 register
  typedef logic [31:0] tdata_t;

  // trigger select as written through tselect
  typedef logic [`DBG_TRIG_IDX_W-1:0] trig_idx_t;

  // one flag per trigger, bit t belongs to trigger t
  typedef logic [`DBG_NUM_TRIGGERS-1:0] trig_vec_t;

  // privilege level of the retired instruction
  typedef logic [1:0] priv_t;

  // only U and M are supported, other levels never match
  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_M = 2'd3;

  // byte lanes touched by one data access
  typedef logic [3:0] byte_mask_t;

endpackage : trig_pkg

// File: project.f
+incdir+logic
logic/trig_pkg.sv
logic/obi_pkg.sv
logic/trig_cfg_regs.sv
logic/trig_match.sv
logic/obi_resp_tracker.sv
logic/dbg_support_top.sv
sim/dbg_support_props.sv
sim/tb_dbg_support.sv

// File: sim/dbg_support_props.sv
`include "dbg_support_macros.svh"

module dbg_support_props (
  input logic                in_support_if,
  input logic                rst_n_i,
  input trig_pkg::trig_vec_t match_execute_i,
  input trig_pkg::trig_vec_t match_load_i,
  input trig_pkg::trig_vec_t match_store_i,
  input logic                bus_rvalid_i,
  input obi_pkg::obi_cnt_t   outstanding_i
);

  // failed assertion count
  int unsigned fail_cnt = 0;

  // an execute hit wipes out every data hit
  a_exec_excl : assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    (|match_execute_i) |-> ((match_load_i == '0) && (match_store_i == '0)))
    else begin
      $error("load or store result alongside an execute result");
      fail_cnt++;
    end

  a_cnt_max : assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    int'(outstanding_i) <= `DBG_OBI_MAX_OUTSTANDING)
    else begin
      $error("outstanding count above the FIFO depth");
      fail_cnt++;
    end

  // a response needs an earlier accepted request
  a_no_orphan : assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    bus_rvalid_i |-> (outstanding_i != '0))
    else begin
      $error("rvalid with nothing outstanding");
      fail_cnt++;
    end

endmodule : dbg_support_props

bind dbg_support_top dbg_support_props u_props (
  .in_support_if   (in_support_if),
  .rst_n_i         (rst_n_i),
  .match_execute_i (match_execute_o),
  .match_load_i    (match_load_o),
  .match_store_i   (match_store_o),
  .bus_rvalid_i    (bus_rvalid_i),
  .outstanding_i   (outstanding_o)
);

// File: sim/tb_dbg_support.sv
`include "dbg_support_macros.svh"

module tb_dbg_support;

  localparam int NUM_BUS_REQ = 24;
  localparam int BUS_TIMEOUT = 2000;
  localparam int DEPTH       = `DBG_OBI_MAX_OUTSTANDING;
  localparam logic [3:0] TY2 = `DBG_TYPE_MCONTROL;
  localparam logic [3:0] TY6 = `DBG_TYPE_MCONTROL6;
  localparam logic [3:0] MEQ = `DBG_MATCH_EQ;
  localparam logic [3:0] MGE = `DBG_MATCH_GE;
  localparam logic [3:0] MLT = `DBG_MATCH_LT;
  localparam trig_pkg::priv_t PM = trig_pkg::PRIV_M;
  localparam trig_pkg::priv_t PU = trig_pkg::PRIV_U;

  logic                 in_support_if = 1'b0;
  logic                 rst_n_i;
  logic                 cfg_we_i;
  trig_pkg::trig_idx_t  cfg_sel_i;
  trig_pkg::tdata_t     cfg_tdata1_i;
  trig_pkg::tdata_t     cfg_tdata2_i;
  trig_pkg::trig_idx_t  rd_sel_i;
  trig_pkg::tdata_t     rd_tdata1_o;
  trig_pkg::tdata_t     rd_tdata2_o;
  logic                 retire_valid_i;
  obi_pkg::obi_addr_t   retire_pc_i;
  trig_pkg::priv_t      retire_priv_i;
  obi_pkg::obi_addr_t   mem_addr_i;
  trig_pkg::byte_mask_t mem_rmask_i;
  trig_pkg::byte_mask_t mem_wmask_i;
  logic                 match_valid_o;
  trig_pkg::trig_vec_t  match_execute_o;
  trig_pkg::trig_vec_t  match_load_o;
  trig_pkg::trig_vec_t  match_store_o;
  logic                 bus_req_i;
  logic                 bus_gnt_i;
  logic                 bus_rvalid_i;
  logic                 bus_req_is_store_i;
  logic                 resp_was_store_o;
  obi_pkg::obi_cnt_t    outstanding_o;
  logic                 addr_ph_cont_o;

  // one table row is an optional config write plus one retirement
  typedef struct {
    logic                 we;
    trig_pkg::trig_idx_t  sel;
    trig_pkg::tdata_t     t1;
    trig_pkg::tdata_t     t2;
    logic                 valid;
    obi_pkg::obi_addr_t   pc;
    trig_pkg::priv_t      priv;
    obi_pkg::obi_addr_t   addr;
    trig_pkg::byte_mask_t rmask;
    trig_pkg::byte_mask_t wmask;
    trig_pkg::trig_vec_t  exp_e;
    trig_pkg::trig_vec_t  exp_l;
    trig_pkg::trig_vec_t  exp_s;
  } row_t;

  row_t        rows[$];
  logic [31:0] lfsr_q = 32'hf7c271fb;

  dbg_support_top u_dut (.*);

  always #5 in_support_if = ~in_support_if;

  // --------------------
  // helpers
  // --------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b = lfsr_q[0];
  endtask

  // xsl holds the execute, store and load enables
  function automatic trig_pkg::tdata_t mcontrol(input logic [3:0] typ, input logic [3:0] mode,
                                                input logic m_en, input logic u_en,
                                                input logic [2:0] xsl);
    trig_pkg::tdata_t v;
    v = '0;
    v[`DBG_TYPE_MSB:`DBG_TYPE_LSB]   = typ;
    v[`DBG_MATCH_MSB:`DBG_MATCH_LSB] = mode;
    v[`DBG_BIT_M_MODE]  = m_en;
    v[`DBG_BIT_U_MODE]  = u_en;
    v[`DBG_BIT_EXECUTE] = xsl[2];
    v[`DBG_BIT_STORE]   = xsl[1];
    v[`DBG_BIT_LOAD]    = xsl[0];
    return v;
  endfunction

  task automatic cfg_row(input trig_pkg::trig_idx_t sel, input trig_pkg::tdata_t t1,
                         input trig_pkg::tdata_t t2);
    rows.push_back('{1'b1, sel, t1, t2, 1'b0, '0, PM, '0, '0, '0, '0, '0, '0});
  endtask

  task automatic ret_row(input obi_pkg::obi_addr_t pc, input trig_pkg::priv_t priv,
                         input obi_pkg::obi_addr_t addr, input trig_pkg::byte_mask_t rm,
                         input trig_pkg::byte_mask_t wm, input trig_pkg::trig_vec_t e,
                         input trig_pkg::trig_vec_t l, input trig_pkg::trig_vec_t s);
    rows.push_back('{1'b0, '0, '0, '0, 1'b1, pc, priv, addr, rm, wm, e, l, s});
  endtask

  // a write in a row governs the rows after it
  task automatic build_table();
    ret_row(32'h100, PM, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    cfg_row(2'd0, mcontrol(TY2, MEQ, 1'b1, 1'b0, 3'b100), 32'h1000);
    ret_row(32'h1000, PM, 32'h0, 4'h0, 4'h0, 4'h1, 4'h0, 4'h0);
    ret_row(32'h1004, PM, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    ret_row(32'h0ffc, PM, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    cfg_row(2'd0, mcontrol(TY2, MGE, 1'b1, 1'b0, 3'b100), 32'h1000);
    ret_row(32'h1000, PM, 32'h0, 4'h0, 4'h0, 4'h1, 4'h0, 4'h0);
    ret_row(32'h2000, PM, 32'h0, 4'h0, 4'h0, 4'h1, 4'h0, 4'h0);
    ret_row(32'h0fff, PM, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    cfg_row(2'd0, mcontrol(TY2, MLT, 1'b1, 1'b0, 3'b100), 32'h1000);
    ret_row(32'h0fff, PM, 32'h0, 4'h0, 4'h0, 4'h1, 4'h0, 4'h0);
    ret_row(32'h1000, PM, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    // byte lanes, trigger 1 loads and trigger 2 stores at lane 2
    cfg_row(2'd0, `DBG_TDATA1_DEFAULT, 32'h0);
    cfg_row(2'd1, mcontrol(TY2, MEQ, 1'b1, 1'b0, 3'b001), 32'h2002);
    cfg_row(2'd2, mcontrol(TY2, MEQ, 1'b1, 1'b0, 3'b010), 32'h3002);
    ret_row(32'h500, PM, 32'h2000, 4'b0100, 4'h0, 4'h0, 4'h2, 4'h0);
    ret_row(32'h500, PM, 32'h2000, 4'b0011, 4'h0, 4'h0, 4'h0, 4'h0);
    ret_row(32'h500, PM, 32'h2000, 4'b1011, 4'h0, 4'h0, 4'h0, 4'h0);
    ret_row(32'h500, PM, 32'h3000, 4'h0, 4'b0100, 4'h0, 4'h0, 4'h4);
    ret_row(32'h500, PM, 32'h3000, 4'h0, 4'b0011, 4'h0, 4'h0, 4'h0);
    // execute hit on trigger 3 masks the data hits
    cfg_row(2'd3, mcontrol(TY2, MEQ, 1'b1, 1'b0, 3'b100), 32'h600);
    ret_row(32'h600, PM, 32'h2000, 4'b0100, 4'h0, 4'h8, 4'h0, 4'h0);
    ret_row(32'h600, PM, 32'h3000, 4'h0, 4'b0100, 4'h8, 4'h0, 4'h0);
    ret_row(32'h604, PM, 32'h2000, 4'b0100, 4'h0, 4'h0, 4'h2, 4'h0);
    // privilege and type filters
    ret_row(32'h600, PU, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    cfg_row(2'd3, mcontrol(TY6, MEQ, 1'b1, 1'b0, 3'b100), 32'h600);
    ret_row(32'h600, PM, 32'h0, 4'h0, 4'h0, 4'h8, 4'h0, 4'h0);
    cfg_row(2'd3, mcontrol(4'd15, MEQ, 1'b1, 1'b0, 3'b100), 32'h600);
    ret_row(32'h600, PM, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    cfg_row(2'd3, mcontrol(TY6, MEQ, 1'b0, 1'b1, 3'b100), 32'h600);
    ret_row(32'h600, PU, 32'h0, 4'h0, 4'h0, 4'h8, 4'h0, 4'h0);
    ret_row(32'h600, PM, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    ret_row(32'h600, 2'd1, 32'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
    // a 2-bit select covers exactly the four triggers, so no select lies out of range
  endtask

  task automatic drive_row(input row_t r);
    cfg_we_i       = r.we;
    cfg_sel_i      = r.sel;
    cfg_tdata1_i   = r.t1;
    cfg_tdata2_i   = r.t2;
    retire_valid_i = r.valid;
    retire_pc_i    = r.pc;
    retire_priv_i  = r.priv;
    mem_addr_i     = r.addr;
    mem_rmask_i    = r.rmask;
    mem_wmask_i    = r.wmask;
    if (r.we) begin
      rd_sel_i = r.sel;
    end
  endtask

  task automatic check_row(input int idx);
    row_t r;
    r = rows[idx];
    check_val($sformatf("match_valid_o row %0d", idx), r.valid, match_valid_o);
    check_val($sformatf("match_execute_o row %0d", idx), r.exp_e, match_execute_o);
    check_val($sformatf("match_load_o row %0d", idx), r.exp_l, match_load_o);
    check_val($sformatf("match_store_o row %0d", idx), r.exp_s, match_store_o);
    if (r.we) begin
      check_val($sformatf("rd_tdata1_o row %0d", idx), r.t1, rd_tdata1_o);
      check_val($sformatf("rd_tdata2_o row %0d", idx), r.t2, rd_tdata2_o);
    end
  endtask

  // --------------------
  // bus sequence
  // --------------------

  task automatic run_bus_sequence();
    int   tally;
    int   sent;
    int   answered;
    int   cycles;
    logic stalled;
    logic b;
    logic flags[$];
    tally    = 0;
    sent     = 0;
    answered = 0;
    cycles   = 0;
    stalled  = 1'b0;
    while (answered < NUM_BUS_REQ) begin
      @(negedge in_support_if);
      cycles++;
      if (cycles > BUS_TIMEOUT) begin
        abort_run("timeout: bus responses did not all arrive");
      end
      check_val("outstanding_o", tally, outstanding_o);
      // a granted request ends its address phase
      if (bus_req_i && bus_gnt_i) begin
        bus_req_i = 1'b0;
      end
      if (!bus_req_i && (sent < NUM_BUS_REQ)) begin
        take_bit(b);
        if (b) begin
          bus_req_i = 1'b1;
          take_bit(bus_req_is_store_i);
        end
      end
      take_bit(b);
      bus_gnt_i = bus_req_i && b && (tally < DEPTH);
      take_bit(b);
      bus_rvalid_i = b && (tally > 0);
      #1;
      check_val("addr_ph_cont_o", bus_req_i && stalled, addr_ph_cont_o);
      if (bus_rvalid_i) begin
        check_val("resp_was_store_o", flags.pop_front(), resp_was_store_o);
        tally--;
        answered++;
      end
      if (bus_req_i && bus_gnt_i) begin
        flags.push_back(bus_req_is_store_i);
        tally++;
        sent++;
      end
      stalled = bus_req_i && !bus_gnt_i;
    end
    @(negedge in_support_if);
    check_val("outstanding_o", tally, outstanding_o);
    bus_req_i    = 1'b0;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    rst_n_i            = 1'b0;
    drive_row('{1'b0, '0, '0, '0, 1'b0, '0, PM, '0, '0, '0, '0, '0, '0});
    rd_sel_i           = '0;
    bus_req_i          = 1'b0;
    bus_gnt_i          = 1'b0;
    bus_rvalid_i       = 1'b0;
    bus_req_is_store_i = 1'b0;
    repeat (3) @(posedge in_support_if);
    @(negedge in_support_if);
    rst_n_i = 1'b1;
    for (int t = 0; t < `DBG_NUM_TRIGGERS; t++) begin
      @(negedge in_support_if);
      rd_sel_i = trig_pkg::trig_idx_t'(t);
      #1;
      check_val("rd_tdata1_o", `DBG_TDATA1_DEFAULT, rd_tdata1_o);
      check_val("rd_tdata2_o", 32'h0, rd_tdata2_o);
    end
    check_val("match_valid_o", 1'b0, match_valid_o);
    check_val("outstanding_o", 32'h0, outstanding_o);
    check_val("addr_ph_cont_o", 1'b0, addr_ph_cont_o);
    build_table();
    // results of row i are checked while row i+1 is presented
    for (int i = 0; i <= rows.size(); i++) begin
      @(negedge in_support_if);
      if (i > 0) begin
        check_row(i - 1);
      end
      if (i < rows.size()) begin
        drive_row(rows[i]);
      end else begin
        cfg_we_i       = 1'b0;
        retire_valid_i = 1'b0;
      end
    end
    run_bus_sequence();
    if (u_dut.u_props.fail_cnt != 0) begin
      abort_run("bound assertions failed during the run");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule : tb_dbg_support
